/* logic/pipe_pkg.sv */
`default_nettype none

package pipe_pkg;

    //////////////////////////////
    // widths
    localparam int word_width     = 16;
    localparam int reg_addr_width = 3;
    localparam int imm_width      = 7;  // rs2 field plus the low tail field

    // instruction opcodes, 3-bit field
    typedef enum logic [2:0] {
        op_add  = 3'd0,
        op_sub  = 3'd1,
        op_and  = 3'd2,
        op_or   = 3'd3,
        op_xor  = 3'd4,
        op_slt  = 3'd5, // signed less-than, 1 or 0
        op_addi = 3'd6,
        op_nop  = 3'd7
    } opcode_t;

    // 16-bit instruction word, msb first
    typedef struct packed {
        opcode_t                   opcode;
        logic [reg_addr_width-1:0] rd;
        logic [reg_addr_width-1:0] rs1;
        logic [reg_addr_width-1:0] rs2;    // upper imm bits for addi
        logic [3:0]                imm_lo; // only addi looks at this
    } inst_t;

    //////////////////////////////
    // stage records
    typedef struct packed {
        logic                      valid;
        opcode_t                   op;
        logic [reg_addr_width-1:0] rs1;
        logic [reg_addr_width-1:0] rs2;
        logic [reg_addr_width-1:0] rd;
        logic                      wr;       // writes a nonzero rd
        logic [word_width-1:0]     imm;      // sign extended
        logic                      uses_imm; // operand two from imm
    } issue_t;

    typedef struct packed {
        logic                      valid;
        logic                      wr;
        logic [reg_addr_width-1:0] rd;
        logic [word_width-1:0]     value;
    } result_t;

    // operand source choice
    typedef enum logic [1:0] {
        fwd_file = 2'd0,
        fwd_ex   = 2'd1,
        fwd_wb   = 2'd2
    } fwd_src_t;

    typedef struct packed {
        fwd_src_t src1;
        fwd_src_t src2;
    } fwd_sel_t;

endpackage

`default_nettype wire

/* logic/decode_stage.sv */
`default_nettype none
`timescale 1ns/1ps

module decode_stage (
    input  logic             clock,
    input  logic             reset,
    input  logic             inst_valid,
    input  pipe_pkg::inst_t  inst,
    output pipe_pkg::issue_t issue
);

    pipe_pkg::issue_t              dec;     // next issue record
    logic [pipe_pkg::imm_width-1:0] raw_imm; // rs2 and tail fields joined

    assign raw_imm = {inst.rs2, inst.imm_lo};

    //////////////////////////////
    // decode
    always_comb begin
        dec.valid    = inst_valid;  // low means a bubble
        dec.op       = inst.opcode;
        dec.rs1      = inst.rs1;
        dec.rs2      = inst.rs2;
        dec.rd       = inst.rd;
        // nop and r0 targets never write the file
        dec.wr       = (inst.opcode != pipe_pkg::op_nop) && (inst.rd != '0);
        dec.imm      = {{(pipe_pkg::word_width - pipe_pkg::imm_width)
                         {raw_imm[pipe_pkg::imm_width-1]}}, raw_imm};
        dec.uses_imm = (inst.opcode == pipe_pkg::op_addi);
    end

    // issue register, one edge after sampling
    always_ff @(posedge clock) begin
        if (reset) begin
            issue <= '0;
        end else begin
            issue <= dec;
        end
    end

    //////////////////////////////
    // checks
    // an unknown valid would poison every stage behind it
    inst_valid_known: assert property (
        @(posedge clock) disable iff (reset)
        !$isunknown(inst_valid)
    ) else $error("inst_valid is unknown");

endmodule

`default_nettype wire

/* logic/reg_file.sv */
`default_nettype none
`timescale 1ns/1ps

module reg_file (
    input  logic                            clock,
    input  logic                            reset,
    input  pipe_pkg::issue_t                issue,
    input  pipe_pkg::result_t               commit,
    output logic [pipe_pkg::word_width-1:0] rdata1,
    output logic [pipe_pkg::word_width-1:0] rdata2
);

    // eight architectural registers
    logic [pipe_pkg::word_width-1:0] regs [0:(2**pipe_pkg::reg_addr_width)-1];

    logic wr_en; // commit writes this edge

    assign wr_en = commit.valid && commit.wr;

    //////////////////////////////
    // write port, from commit
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < 2**pipe_pkg::reg_addr_width; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            // wr is never set for rd zero, so r0 stays zero
            regs[commit.rd] <= commit.value;
        end
    end

    //////////////////////////////
    // read ports
    // combinational, at the decoded source indices
    // a value written at this edge is visible right after it
    always_comb begin
        rdata1 = regs[issue.rs1];
        rdata2 = regs[issue.rs2];
    end

endmodule

`default_nettype wire

/* logic/forward_unit.sv */
`default_nettype none
`timescale 1ns/1ps

module forward_unit (
    input  pipe_pkg::issue_t  issue,
    input  pipe_pkg::result_t ex_res,
    input  pipe_pkg::result_t commit,
    output pipe_pkg::fwd_sel_t fwd
);

    // pick the source of one operand
    // newest writer first, ex_res is one place older, commit two
    function automatic pipe_pkg::fwd_src_t pick_src(
        input logic [pipe_pkg::reg_addr_width-1:0] src,
        input pipe_pkg::result_t                   ex,
        input pipe_pkg::result_t                   wb
    );
        logic ex_hit; // writer in execute register
        logic wb_hit; // writer in commit register
        ex_hit = ex.valid && ex.wr && (ex.rd == src);
        wb_hit = wb.valid && wb.wr && (wb.rd == src);
        if (ex_hit) begin
            return pipe_pkg::fwd_ex;
        end else if (wb_hit) begin
            return pipe_pkg::fwd_wb;
        end
        return pipe_pkg::fwd_file; // older writers already in the file
    endfunction

    //////////////////////////////
    // per-source selection
    always_comb begin
        fwd.src1 = pick_src(issue.rs1, ex_res, commit);
        fwd.src2 = pick_src(issue.rs2, ex_res, commit); // addi ignores this one
    end

endmodule

`default_nettype wire

/* logic/execute_stage.sv */
`default_nettype none
`timescale 1ns/1ps

module execute_stage (
    input  logic                            clock,
    input  logic                            reset,
    input  pipe_pkg::issue_t                issue,
    input  logic [pipe_pkg::word_width-1:0] rdata1,
    input  logic [pipe_pkg::word_width-1:0] rdata2,
    input  pipe_pkg::fwd_sel_t              fwd,
    output pipe_pkg::result_t               ex_res,
    output pipe_pkg::result_t               commit
);

    logic [pipe_pkg::word_width-1:0] op_a;    // operand one after forwarding
    logic [pipe_pkg::word_width-1:0] op_b;    // operand two, maybe the imm
    logic [pipe_pkg::word_width-1:0] alu_out;
    logic                            lt;      // signed a < b

    // one operand mux, file or one of the two in-flight results
    function automatic logic [pipe_pkg::word_width-1:0] sel_operand(
        input pipe_pkg::fwd_src_t               src,
        input logic [pipe_pkg::word_width-1:0] file_val,
        input logic [pipe_pkg::word_width-1:0] ex_val,
        input logic [pipe_pkg::word_width-1:0] wb_val
    );
        case (src)
            pipe_pkg::fwd_ex: return ex_val;
            pipe_pkg::fwd_wb: return wb_val;
            default:          return file_val;
        endcase
    endfunction

    //////////////////////////////
    // operand select
    always_comb begin
        op_a = sel_operand(fwd.src1, rdata1, ex_res.value, commit.value);
        op_b = sel_operand(fwd.src2, rdata2, ex_res.value, commit.value);
        if (issue.uses_imm) begin
            op_b = issue.imm; // addi, rs2 field is part of the imm
        end
    end

    //////////////////////////////
    // alu
    assign lt = $signed(op_a) < $signed(op_b);

    always_comb begin
        case (issue.op)
            pipe_pkg::op_add,
            pipe_pkg::op_addi: alu_out = op_a + op_b;
            pipe_pkg::op_sub:  alu_out = op_a - op_b;
            pipe_pkg::op_and:  alu_out = op_a & op_b;
            pipe_pkg::op_or:   alu_out = op_a | op_b;
            pipe_pkg::op_xor:  alu_out = op_a ^ op_b;
            pipe_pkg::op_slt:  alu_out = {{(pipe_pkg::word_width-1){1'b0}}, lt};
            default:           alu_out = '0; // nop
        endcase
    end

    //////////////////////////////
    // execute and commit registers
    always_ff @(posedge clock) begin
        if (reset) begin
            ex_res <= '0;
            commit <= '0;
        end else begin
            ex_res.valid <= issue.valid;
            ex_res.wr    <= issue.wr;
            ex_res.rd    <= issue.rd;
            ex_res.value <= alu_out;
            commit       <= ex_res; // one more edge, then the file
        end
    end

    //////////////////////////////
    // checks
    // forward unit must only point at a live stage
    fwd_ex_live: assert property (
        @(posedge clock) disable iff (reset)
        (fwd.src1 == pipe_pkg::fwd_ex || fwd.src2 == pipe_pkg::fwd_ex) |-> ex_res.valid
    ) else $error("forward from execute while ex_res is empty");

    fwd_wb_live: assert property (
        @(posedge clock) disable iff (reset)
        (fwd.src1 == pipe_pkg::fwd_wb || fwd.src2 == pipe_pkg::fwd_wb) |-> commit.valid
    ) else $error("forward from commit while commit is empty");

endmodule

`default_nettype wire

/* logic/alu_pipe.sv */
`default_nettype none
`timescale 1ns/1ps

module alu_pipe (
    input  logic              clock,
    input  logic              reset,
    input  logic              inst_valid,
    input  pipe_pkg::inst_t   inst,
    output pipe_pkg::result_t commit
);

    pipe_pkg::issue_t                issue;  // decode register
    pipe_pkg::result_t               ex_res; // execute register
    pipe_pkg::fwd_sel_t              fwd;
    logic [pipe_pkg::word_width-1:0] rdata1;
    logic [pipe_pkg::word_width-1:0] rdata2;

    //////////////////////////////
    // decode, edge n
    decode_stage decode_stage_i (
        .clock      (clock),
        .reset      (reset),
        .inst_valid (inst_valid),
        .inst       (inst),
        .issue      (issue)
    );

    //////////////////////////////
    // operand read, side by side
    reg_file reg_file_i (
        .clock  (clock),
        .reset  (reset),
        .issue  (issue),
        .commit (commit), // write back from commit
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    forward_unit forward_unit_i (
        .issue  (issue),
        .ex_res (ex_res),
        .commit (commit),
        .fwd    (fwd)
    );

    //////////////////////////////
    // execute n+1, commit n+2
    execute_stage execute_stage_i (
        .clock  (clock),
        .reset  (reset),
        .issue  (issue),
        .rdata1 (rdata1),
        .rdata2 (rdata2),
        .fwd    (fwd),
        .ex_res (ex_res),
        .commit (commit)
    );

endmodule

`default_nettype wire

/* dv/clock_gen.sv */
`default_nettype none
`timescale 1ns/1ps

module clock_gen (
    output logic clock,
    output logic reset
);

    localparam int half_period  = 50; // 100 ns clock
    localparam int reset_cycles = 16;

    initial begin
        clock = 1'b0;
        forever #half_period clock = ~clock;
    end

    // sync reset, dropped just after the last reset edge
    initial begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge clock);
        #1 reset = 1'b0;
    end

endmodule

`default_nettype wire

/* dv/alu_pipe_tb.sv */
`default_nettype none
`timescale 1ns/1ps

module alu_pipe_tb;

    // one expected commit and the edge it is due after
    typedef struct packed {
        pipe_pkg::result_t res;
        logic [31:0]       edge_no;
    } exp_entry_t;

    logic              clock;
    logic              reset;
    logic              inst_valid;
    pipe_pkg::inst_t   inst;
    pipe_pkg::result_t commit;

    logic [15:0] arch_regs [0:7]; // architectural model state
    exp_entry_t  exp_q[$];        // in-order expected commits
    logic [31:0] rng_state;
    logic [31:0] edge_count;      // rising edges since start
    string       cur_test;
    int          errors;
    int          checks;
    int          err_start;
    int          tests_run;
    int          tests_bad;
    logic        timed_out;

    clock_gen clock_gen_i (.clock(clock), .reset(reset));

    alu_pipe alu_pipe_i (
        .clock      (clock),
        .reset      (reset),
        .inst_valid (inst_valid),
        .inst       (inst),
        .commit     (commit)
    );

    //////////////////////////////
    // random numbers, lcg
    function automatic logic [15:0] next_rand();
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return rng_state[30:15]; // drop the weak low bits
    endfunction

    function automatic logic [2:0] rand_reg(input int span);
        return 3'(next_rand() % span); // 0 .. span-1
    endfunction

    function automatic logic [3:0] rand_tail();
        return 4'(next_rand());
    endfunction

    function automatic pipe_pkg::opcode_t rand_op(input int span);
        return pipe_pkg::opcode_t'(3'(next_rand() % span));
    endfunction

    //////////////////////////////
    // stimulus and model
    // model runs at issue time, in program order
    task automatic issue_inst(input pipe_pkg::opcode_t op, input logic [2:0] rd,
                              input logic [2:0] rs1, input logic [2:0] rs2,
                              input logic [3:0] tail);
        pipe_pkg::inst_t i;
        exp_entry_t      e;
        logic [15:0]     a;
        logic [15:0]     b;
        logic [15:0]     imm;
        logic [15:0]     val;
        i.opcode = op;
        i.rd     = rd;
        i.rs1    = rs1;
        i.rs2    = rs2;
        i.imm_lo = tail;
        a   = arch_regs[rs1];
        b   = arch_regs[rs2];
        imm = {{9{rs2[2]}}, rs2, tail}; // signed 7-bit imm
        case (op)
            pipe_pkg::op_add:  val = a + b;
            pipe_pkg::op_sub:  val = a - b;
            pipe_pkg::op_and:  val = a & b;
            pipe_pkg::op_or:   val = a | b;
            pipe_pkg::op_xor:  val = a ^ b;
            pipe_pkg::op_slt:  val = ($signed(a) < $signed(b)) ? 16'd1 : 16'd0;
            pipe_pkg::op_addi: val = a + imm;
            default:           val = 16'd0; // nop
        endcase
        e.res.valid = 1'b1;
        e.res.wr    = (op != pipe_pkg::op_nop) && (rd != 3'd0);
        e.res.rd    = rd;
        e.res.value = val;
        e.edge_no   = edge_count + 32'd3; // sampled next edge, on commit two later
        if (e.res.wr) begin
            arch_regs[rd] = val;
        end
        exp_q.push_back(e);
        inst_valid = 1'b1;
        inst       = i;
        @(posedge clock);
        #1;
    endtask

    // cycle with no instruction, garbage on inst
    task automatic bubble();
        inst_valid = 1'b0;
        inst       = pipe_pkg::inst_t'(next_rand());
        @(posedge clock);
        #1;
    endtask

    //////////////////////////////
    // commit monitor, mid cycle
    always @(posedge clock) begin
        edge_count <= edge_count + 32'd1;
    end

    always @(negedge clock) begin
        exp_entry_t e;
        if (!reset && commit.valid) begin
            checks++;
            if (exp_q.size() == 0) begin
                $display("%s: commit of r%0d with no instruction outstanding",
                         cur_test, commit.rd);
                errors++;
            end else begin
                e = exp_q.pop_front();
                if (commit !== e.res) begin
                    $display(
                        "ERR %s: expected wr=%b rd=%0d value=%h, actual wr=%b rd=%0d value=%h",
                        cur_test, e.res.wr, e.res.rd, e.res.value,
                        commit.wr, commit.rd, commit.value);
                    errors++;
                end
                if (edge_count != e.edge_no) begin
                    $display("ERR %s latency: expected edge %0d, actual edge %0d",
                             cur_test, e.edge_no, edge_count);
                    errors++;
                end
            end
        end
    end

    //////////////////////////////
    // test bookkeeping
    task automatic start_test(input string name);
        cur_test  = name;
        err_start = errors;
        tests_run++;
    endtask

    task automatic end_test();
        int waited;
        waited     = 0;
        inst_valid = 1'b0;
        while (exp_q.size() != 0 && waited < 20) begin // drain with a bound
            @(posedge clock);
            #1;
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("%s: timed out, %0d results never reached commit", cur_test, exp_q.size());
            timed_out = 1'b1;
            errors++;
        end
        if (errors != err_start) begin
            tests_bad++;
        end
        $display("test %s done, %0d errors", cur_test, errors - err_start);
    endtask

    task automatic wait_reset_done();
        int waited;
        waited = 0;
        do begin // look only after the first edge
            @(posedge clock);
            waited++;
        end while (reset !== 1'b0 && waited < 40);
        if (reset !== 1'b0) begin
            $display("reset never released");
            timed_out = 1'b1;
            errors++;
        end
        #1;
    endtask

    //////////////////////////////
    // tests
    task automatic test_reset();
        start_test("reset");
        for (int k = 0; k < 6; k++) begin // idle, nothing may commit
            checks++;
            if (commit.valid !== 1'b0) begin
                $display("ERR %s: expected commit.valid 0, actual %b", cur_test, commit.valid);
                errors++;
            end
            bubble();
        end
        for (int r = 0; r < 8; r++) begin
            issue_inst(pipe_pkg::op_add, 3'(r), 3'(r), 3'd0, 4'd0); // each reg + r0
        end
        end_test();
    endtask

    task automatic test_opcodes();
        start_test("opcodes");
        for (int r = 1; r < 8; r++) begin
            issue_inst(pipe_pkg::op_addi, 3'(r), 3'd0, rand_reg(8), rand_tail());
        end
        for (int k = 0; k < 16; k++) begin // spread values over 16 bits
            issue_inst(rand_op(5), 3'(rand_reg(7) + 3'd1), rand_reg(8), rand_reg(8), 4'd0);
        end
        for (int op = 0; op < 8; op++) begin
            for (int k = 0; k < 4; k++) begin
                issue_inst(pipe_pkg::opcode_t'(3'(op)), rand_reg(8), rand_reg(8),
                           rand_reg(8), rand_tail());
            end
        end
        end_test();
    endtask

    task automatic test_fwd_ex();
        logic [2:0] rd;
        logic [2:0] other;
        int         mode;
        start_test("fwd_ex");
        for (int k = 0; k < 12; k++) begin
            rd    = 3'(rand_reg(7) + 3'd1);
            other = rand_reg(8);
            mode  = int'(next_rand() % 3);
            issue_inst(pipe_pkg::op_addi, rd, rand_reg(8), rand_reg(8), rand_tail());
            case (mode) // reader right behind the writer
                0:       issue_inst(rand_op(6), rand_reg(8), rd, other, 4'd0);
                1:       issue_inst(rand_op(6), rand_reg(8), other, rd, 4'd0);
                default: issue_inst(rand_op(6), rand_reg(8), rd, rd, 4'd0);
            endcase
        end
        end_test();
    endtask

    task automatic test_fwd_wb();
        logic [2:0] rd;
        start_test("fwd_wb");
        for (int k = 0; k < 12; k++) begin
            rd = 3'(rand_reg(7) + 3'd1);
            issue_inst(pipe_pkg::op_addi, rd, rand_reg(8), rand_reg(8), rand_tail());
            if (k % 3 == 0) begin
                bubble(); // gap as a bubble
            end else begin
                issue_inst(pipe_pkg::op_xor, rd ^ 3'd7, rand_reg(8), rand_reg(8), 4'd0);
            end
            issue_inst(rand_op(6), rand_reg(8), rd, rand_reg(8), 4'd0);
        end
        // two writers of one reg, nearer must win
        for (int k = 0; k < 8; k++) begin
            rd = 3'(rand_reg(7) + 3'd1);
            issue_inst(pipe_pkg::op_addi, rd, 3'd0, rand_reg(8), rand_tail());
            issue_inst(pipe_pkg::op_addi, rd, 3'd0, rand_reg(8), rand_tail());
            issue_inst(pipe_pkg::op_add, rand_reg(8), rd, rd, 4'd0);
        end
        end_test();
    endtask

    task automatic test_r0_bubbles();
        start_test("r0_bubbles");
        issue_inst(pipe_pkg::op_addi, 3'd0, 3'd0, 3'd3, 4'hf); // wr must stay low
        issue_inst(pipe_pkg::op_nop, rand_reg(8), rand_reg(8), rand_reg(8), rand_tail());
        issue_inst(pipe_pkg::op_sub, 3'd0, 3'd5, 3'd2, 4'd0);
        issue_inst(pipe_pkg::op_add, 3'd1, 3'd0, 3'd0, 4'd0); // r0 still reads zero
        issue_inst(pipe_pkg::op_or, 3'd2, 3'd0, 3'd0, 4'd0);
        for (int k = 0; k < 24; k++) begin
            if (next_rand() % 2 == 0) begin
                bubble();
            end else begin
                issue_inst(rand_op(8), rand_reg(3), rand_reg(3), rand_reg(3), rand_tail());
            end
        end
        end_test();
    endtask

    task automatic test_random();
        start_test("random");
        for (int k = 0; k < 400; k++) begin
            if (next_rand() % 5 == 0) begin
                bubble();
            end else begin // few regs, dense reuse
                issue_inst(rand_op(8), rand_reg(4), rand_reg(4), rand_reg(4), rand_tail());
            end
        end
        end_test();
    endtask

    //////////////////////////////
    // main
    initial begin
        inst_valid = 1'b0;
        inst       = '0;
        rng_state  = 32'd96;
        edge_count = '0;
        errors     = 0;
        checks     = 0;
        err_start  = 0;
        tests_run  = 0;
        tests_bad  = 0;
        timed_out  = 1'b0;
        cur_test   = "setup";
        for (int r = 0; r < 8; r++) begin
            arch_regs[r] = '0;
        end
        wait_reset_done();
        if (!timed_out) test_reset();
        if (!timed_out) test_opcodes();
        if (!timed_out) test_fwd_ex();
        if (!timed_out) test_fwd_wb();
        if (!timed_out) test_r0_bubbles();
        if (!timed_out) test_random();
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_bad, checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
logic/pipe_pkg.sv
logic/decode_stage.sv
logic/reg_file.sv
logic/forward_unit.sv
logic/execute_stage.sv
logic/alu_pipe.sv
dv/clock_gen.sv
dv/alu_pipe_tb.sv

/* Makefile */
TOP = alu_pipe_tb

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing --assert -sv -f list.f --top-module $(TOP) -Mdir obj_dir -o sim
	./obj_dir/sim | tee /dev/stderr | grep -qF '*** PASSED ***'

lint:
	verilator --lint-only --timing -sv -f list.f --top-module $(TOP)
	verilator --lint-only -sv logic/pipe_pkg.sv logic/decode_stage.sv logic/reg_file.sv \
		logic/forward_unit.sv logic/execute_stage.sv logic/alu_pipe.sv --top-module alu_pipe

clean:
	rm -rf obj_dir
